// ==== verilog/stack_isa_pkg.sv ====
package stack_isa_pkg;

	localparam int opcode_w = 6; // Fixed by the 64-entry opcode table

	// Opcode map, in the order the assembler emits them
	typedef enum logic [opcode_w-1:0] {
		LOAD   = 6'd0,  // Load accumulator from memory
		PLD,            // Push then load
		SET,            // Store accumulator to memory
		SETP,           // Store and pop, used for call parameters
		PUSH,
		JZ,             // Branches are resolved in prefetch
		JMP,
		CALL,
		RETURN,
		SRF,            // Set register file
		IN,             // Data input
		OUT,            // Data output
		NEG,            // Two's complement of accumulator
		ADD,
		SADD,
		MLT,
		SMLT,
		DIV,
		SDIV,
		MOD,
		SMOD,
		AND,
		SAND,
		LAND,
		SLAND,
		OR,
		SOR,
		LOR,
		SLOR,
		XOR,
		SXOR,
		INV,            // Bitwise invert of accumulator
		LINV,           // Logical invert, unary so no stack form
		EQU,
		SEQU,
		GRE,
		SGRE,
		LES,
		SLES,
		SHR,
		SSHR,
		SHL,
		SSHL,
		SRS,            // Arithmetic shift right
		SSRS,
		PST,            // Accumulator or zero if negative
		SSIGN,
		NORM,           // Divide accumulator by a constant
		FIA,            // Float to int on accumulator
		ABS,
		ILDI,           // Indirect load with inverted bits
		SIGN,
		LDI,            // Indirect load, offset in accumulator
		ISRF,           // SRF with inverted bits
		FIM,
		PFIM,
		IFA,            // Int to float on accumulator
		IFM,
		PIFM,
		NEGM,
		PNEGM,
		FNEG,
		FNEGM,
		PFNEGM = 6'd63
	} opcode_t;

	// Operation select seen by the ALU
	typedef enum logic [4:0] {
		ALU_PASS_A = 5'd0,
		ALU_LOAD   = 5'd1,
		ALU_ADD    = 5'd2,
		ALU_MLT    = 5'd3,
		ALU_DIV    = 5'd4,
		ALU_MOD    = 5'd5,
		ALU_NEG    = 5'd6,
		ALU_NORM   = 5'd7,
		ALU_ABS    = 5'd8,
		ALU_PST    = 5'd9,
		ALU_SIGN   = 5'd10,
		ALU_OR     = 5'd11,
		ALU_AND    = 5'd12,
		ALU_INV    = 5'd13,
		ALU_XOR    = 5'd14,
		ALU_LES    = 5'd15,
		ALU_GRE    = 5'd16,
		ALU_EQU    = 5'd17,
		ALU_LINV   = 5'd18,
		ALU_LAND   = 5'd19,
		ALU_LOR    = 5'd20,
		ALU_SHL    = 5'd21,
		ALU_SHR    = 5'd22,
		ALU_SRS    = 5'd23,
		ALU_FIA    = 5'd24,
		ALU_FIM    = 5'd25,
		ALU_IFA    = 5'd26,
		ALU_IFM    = 5'd27,
		ALU_NEGM   = 5'd28,
		ALU_FNEG   = 5'd29,
		ALU_FNEGM  = 5'd30
	} alu_op_t;

endpackage

// ==== verilog/mem_stack_ctrl.sv ====
module mem_stack_ctrl (
	input  stack_isa_pkg::opcode_t opcode,
	output logic                   mem_wr,
	output logic                   dsp_push,
	output logic                   dsp_pop,
	output logic                   ldi,
	output logic                   inv_load
);

	import stack_isa_pkg::*;

	// Side effects act in the fetch cycle, so this stays combinational
	always_comb begin
		mem_wr   = 1'b0;
		dsp_push = 1'b0;
		dsp_pop  = 1'b0;
		ldi      = 1'b0;
		inv_load = 1'b0;
		case (opcode)
			PLD,
			PUSH,
			PFIM,
			PIFM,
			PNEGM,
			PFNEGM: begin // Push-prefixed forms save the accumulator first
				mem_wr   = 1'b1;
				dsp_push = 1'b1;
			end
			SET: begin
				mem_wr = 1'b1;
			end
			SETP: begin
				mem_wr  = 1'b1;
				dsp_pop = 1'b1;
			end
			SRF,
			OUT,
			ISRF,
			SADD,   // Second operand comes off the stack
			SMLT,
			SDIV,
			SMOD,
			SAND,
			SLAND,
			SOR,
			SLOR,
			SXOR,
			LINV,
			SEQU,
			SGRE,
			SLES,
			SSHR,
			SSHL,
			SSRS,
			SSIGN: begin
				dsp_pop = 1'b1;
			end
			ILDI: begin
				ldi      = 1'b1;
				inv_load = 1'b1; // Address bits flipped on the load side
			end
			LDI: begin
				ldi = 1'b1;
			end
			LOAD,
			JZ,
			JMP,
			CALL,
			RETURN,
			IN,
			NEG,
			ADD,
			MLT,
			DIV,
			MOD,
			AND,
			LAND,
			OR,
			LOR,
			XOR,
			INV,
			EQU,
			GRE,
			LES,
			SHR,
			SHL,
			SRS,
			PST,
			NORM,
			FIA,
			ABS,
			SIGN,
			FIM,
			IFA,
			IFM,
			NEGM,
			FNEG,
			FNEGM: begin
				mem_wr = 1'b0; // Accumulator and memory operand only
			end
		endcase
	end

endmodule

// ==== verilog/alu_op_decode.sv ====
module alu_op_decode (
	input                          clk,
	input                          rst,
	input  stack_isa_pkg::opcode_t opcode,
	output stack_isa_pkg::alu_op_t ula_op,
	output logic                   srf,
	output logic                   inv_reg,
	output logic                   req_in,
	output logic                   out_en
);

	import stack_isa_pkg::*;

	alu_op_t op_nxt;
	logic    srf_nxt;
	logic    inv_nxt;
	logic    req_nxt;
	logic    out_nxt;

	// One entry per opcode, the ALU sees the result one cycle after fetch
	always_comb begin
		op_nxt  = ALU_PASS_A;
		srf_nxt = 1'b0;
		inv_nxt = 1'b0;
		req_nxt = 1'b0;
		out_nxt = 1'b0;
		case (opcode)
			LOAD   : op_nxt = ALU_LOAD;
			PLD    : op_nxt = ALU_LOAD;
			SET    : op_nxt = ALU_PASS_A;
			SETP   : op_nxt = ALU_LOAD;
			PUSH   : op_nxt = ALU_PASS_A;
			JZ     : op_nxt = ALU_PASS_A;
			JMP    : op_nxt = ALU_PASS_A;
			CALL   : op_nxt = ALU_PASS_A;
			RETURN : op_nxt = ALU_PASS_A;
			SRF: begin
				op_nxt  = ALU_PASS_A;
				srf_nxt = 1'b1;
			end
			IN: begin
				op_nxt  = ALU_LOAD; // Input word goes through the load path
				req_nxt = 1'b1;
			end
			OUT: begin
				op_nxt  = ALU_PASS_A;
				out_nxt = 1'b1;
			end
			NEG    : op_nxt = ALU_NEG;
			ADD    : op_nxt = ALU_ADD;
			SADD   : op_nxt = ALU_ADD;
			MLT    : op_nxt = ALU_MLT;
			SMLT   : op_nxt = ALU_MLT;
			DIV    : op_nxt = ALU_DIV;
			SDIV   : op_nxt = ALU_DIV;
			MOD    : op_nxt = ALU_MOD;
			SMOD   : op_nxt = ALU_MOD;
			AND    : op_nxt = ALU_AND;
			SAND   : op_nxt = ALU_AND;
			LAND   : op_nxt = ALU_LAND;
			SLAND  : op_nxt = ALU_LAND;
			OR     : op_nxt = ALU_OR;
			SOR    : op_nxt = ALU_OR;
			LOR    : op_nxt = ALU_LOR;
			SLOR   : op_nxt = ALU_LOR;
			XOR    : op_nxt = ALU_XOR;
			SXOR   : op_nxt = ALU_XOR;
			INV    : op_nxt = ALU_INV;
			LINV   : op_nxt = ALU_LINV;
			EQU    : op_nxt = ALU_EQU;
			SEQU   : op_nxt = ALU_EQU;
			GRE    : op_nxt = ALU_GRE;
			SGRE   : op_nxt = ALU_GRE;
			LES    : op_nxt = ALU_LES;
			SLES   : op_nxt = ALU_LES;
			SHR    : op_nxt = ALU_SHR;
			SSHR   : op_nxt = ALU_SHR;
			SHL    : op_nxt = ALU_SHL;
			SSHL   : op_nxt = ALU_SHL;
			SRS    : op_nxt = ALU_SRS;
			SSRS   : op_nxt = ALU_SRS;
			PST    : op_nxt = ALU_PST;
			SSIGN  : op_nxt = ALU_SIGN;  // Same unit as SIGN
			NORM   : op_nxt = ALU_NORM;
			FIA    : op_nxt = ALU_FIA;
			ABS    : op_nxt = ALU_ABS;
			ILDI   : op_nxt = ALU_LOAD;
			SIGN   : op_nxt = ALU_SIGN;
			LDI    : op_nxt = ALU_LOAD;
			ISRF: begin
				op_nxt  = ALU_PASS_A;
				srf_nxt = 1'b1;
				inv_nxt = 1'b1; // Register side of the inversion flag
			end
			FIM    : op_nxt = ALU_FIM;
			PFIM   : op_nxt = ALU_FIM;
			IFA    : op_nxt = ALU_IFA;
			IFM    : op_nxt = ALU_IFM;
			PIFM   : op_nxt = ALU_IFM;
			NEGM   : op_nxt = ALU_NEGM;
			PNEGM  : op_nxt = ALU_NEGM;
			FNEG   : op_nxt = ALU_FNEG;
			FNEGM  : op_nxt = ALU_FNEGM;
			PFNEGM : op_nxt = ALU_FNEGM;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ula_op  <= ALU_PASS_A;
			srf     <= 1'b0;
			inv_reg <= 1'b0;
			req_in  <= 1'b0;
			out_en  <= 1'b0;
		end else begin
			ula_op  <= op_nxt;
			srf     <= srf_nxt;
			inv_reg <= inv_nxt;
			req_in  <= req_nxt;
			out_en  <= out_nxt;
		end
	end

endmodule

// ==== verilog/instr_dec.sv ====
module instr_dec #(
	parameter int NBDATA = 32, // Data word width
	parameter int NBOPER = 9,  // Operand field width
	parameter int MDATAW = 8   // Data memory address width
) (
	input                          clk,
	input                          rst,
	input  stack_isa_pkg::opcode_t opcode,
	input  logic [NBOPER-1:0]      operand,
	input  logic [NBDATA-1:0]      mem_data_in,
	input  logic [NBDATA-1:0]      io_in,
	output stack_isa_pkg::alu_op_t ula_op,
	output logic [NBDATA-1:0]      ula_data,
	output logic [MDATAW-1:0]      mem_addr,
	output logic                   mem_wr,
	output logic                   dsp_push,
	output logic                   dsp_pop,
	output logic                   ldi,
	output logic                   srf,
	output logic                   inv,
	output logic                   req_in,
	output logic                   out_en
);

	logic inv_reg;  // From ISRF, one cycle late
	logic inv_load; // From ILDI, same cycle

	alu_op_decode i_alu_op_decode (
		.clk     (clk),
		.rst     (rst),
		.opcode  (opcode),
		.ula_op  (ula_op),
		.srf     (srf),
		.inv_reg (inv_reg),
		.req_in  (req_in),
		.out_en  (out_en)
	);

	mem_stack_ctrl i_mem_stack_ctrl (
		.opcode   (opcode),
		.mem_wr   (mem_wr),
		.dsp_push (dsp_push),
		.dsp_pop  (dsp_pop),
		.ldi      (ldi),
		.inv_load (inv_load)
	);

	// Either half can request inverted bits
	assign inv = inv_reg | inv_load;

	// Registered req_in steers the input port into the ALU during execute
	assign ula_data = req_in ? io_in : mem_data_in;

	assign mem_addr = operand[MDATAW-1:0]; // Direct address from the operand field

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period  = 10; // 20 ns clock
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#2 rst = 1'b0; // Release clear of the edge
	end

endmodule

// ==== bench/instr_dec_properties.sv ====
module instr_dec_properties (
	input logic       clk,
	input logic       rst,
	input logic [4:0] ula_op,
	input logic       srf,
	input logic       inv,
	input logic       inv_reg,
	input logic       req_in,
	input logic       out_en,
	input logic       ldi,
	input logic       dsp_push,
	input logic       dsp_pop
);
	timeunit 1ns;
	timeprecision 100ps;

	// Registered half stays cleared for the whole reset pulse
	a_reset_clear: assert property (@(posedge clk)
		(rst && $past(rst)) |-> (ula_op == 5'd0 && !srf && !inv_reg && !req_in && !out_en))
		else $error("registered outputs not cleared while rst is high");

	a_stack_excl: assert property (@(posedge clk) disable iff (rst) !(dsp_push && dsp_pop))
		else $error("dsp_push and dsp_pop high in the same cycle");

	a_io_excl: assert property (@(posedge clk) disable iff (rst) !(req_in && out_en))
		else $error("req_in and out_en high in the same cycle");

	// Inversion only comes from ILDI or ISRF
	a_inv_source: assert property (@(posedge clk) disable iff (rst) inv |-> (ldi || srf))
		else $error("inv high without ldi or srf");

endmodule

// ==== bench/instr_dec_tb.sv ====
module instr_dec_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int nbdata = 32;
	localparam int nboper = 9;
	localparam int mdataw = 8;
	localparam int watchdog_cycles = 16 + 6 * 64 + 100;

	// Expected ALU operation, indexed by opcode
	localparam int alu_ref [64] = '{
		1, 1, 0, 1, 0, 0, 0, 0, 0, 0, 1, 0, 6, 2, 2, 3,
		3, 4, 4, 5, 5, 12, 12, 19, 19, 11, 11, 20, 20, 14, 14, 13,
		18, 17, 17, 16, 16, 15, 15, 22, 22, 21, 21, 23, 23, 9, 10, 7,
		24, 8, 1, 10, 1, 0, 25, 25, 26, 27, 27, 28, 28, 29, 30, 30
	};

	logic                   clk;
	logic                   rst;
	stack_isa_pkg::opcode_t opcode;
	logic [nboper-1:0]      operand;
	logic [nbdata-1:0]      mem_data_in;
	logic [nbdata-1:0]      io_in;
	stack_isa_pkg::alu_op_t ula_op;
	logic [nbdata-1:0]      ula_data;
	logic [mdataw-1:0]      mem_addr;
	logic                   mem_wr, dsp_push, dsp_pop, ldi;
	logic                   srf, inv, req_in, out_en;
	logic [31:0]            lfsr_state = 32'h6d940e8b;
	int                     test_errors;
	int                     tests_passed;
	int                     tests_failed;

	tb_clock_gen i_clock_gen (.clk(clk), .rst(rst));

	instr_dec #(.NBDATA(nbdata), .NBOPER(nboper), .MDATAW(mdataw)) i_dut (.*);

	bind instr_dec instr_dec_properties i_props (
		.clk(clk), .rst(rst), .ula_op(ula_op), .srf(srf), .inv(inv), .inv_reg(inv_reg),
		.req_in(req_in), .out_en(out_en), .ldi(ldi), .dsp_push(dsp_push), .dsp_pop(dsp_pop)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic draw_random(input int nbits, output logic [31:0] value);
		value = '0;
		repeat (nbits) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// {mem_wr, dsp_push, dsp_pop, ldi, inv_load}
	function automatic logic [4:0] side_effects(input int op);
		logic push_load;
		logic pop;
		push_load = op == 1 || op == 4 || op == 55 || op == 58 || op == 60 || op == 63;
		pop = op == 3 || op == 9 || op == 11 || op == 53 || op == 46
			|| (op >= 14 && op <= 44 && op % 2 == 0);
		return {push_load || op == 2 || op == 3, push_load, pop, op == 50 || op == 52, op == 50};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
			test_errors++;
		end
	endtask

	task report_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task next_drive_point;
		@(posedge clk);
		#2;
	endtask

	task drive_opcode(input int op);
		opcode = stack_isa_pkg::opcode_t'(op[5:0]);
	endtask

	task check_cleared;
		check_value("ula_op", 32'(ula_op), 0);
		check_value("srf", 32'(srf), 0);
		check_value("req_in", 32'(req_in), 0);
		check_value("out_en", 32'(out_en), 0);
		check_value("inv", 32'(inv), 0);
	endtask

	task reset_check;
		repeat (4) @(posedge clk);
		#2;
		check_cleared();
		@(negedge rst);
		#1; // Before the first edge out of reset
		check_cleared();
		report_test("reset");
	endtask

	task comb_sweep;
		logic [4:0] exp;
		for (int op = 0; op < 64; op++) begin
			next_drive_point();
			drive_opcode(op);
			#1;
			exp = side_effects(op);
			check_value("mem_wr", 32'(mem_wr), 32'(exp[4]));
			check_value("dsp_push", 32'(dsp_push), 32'(exp[3]));
			check_value("dsp_pop", 32'(dsp_pop), 32'(exp[2]));
			check_value("ldi", 32'(ldi), 32'(exp[1]));
			if (op != 54) check_value("inv", 32'(inv), 32'(exp[0])); // ISRF was in flight
		end
		report_test("comb_sweep");
	endtask

	task reg_sweep;
		int prev;
		for (int op = 0; op <= 64; op++) begin
			next_drive_point();
			prev = op - 1;
			if (op > 0) begin
				check_value("ula_op", 32'(ula_op), alu_ref[prev[5:0]]);
				check_value("srf", 32'(srf), 32'(prev == 9 || prev == 53));
				check_value("req_in", 32'(req_in), 32'(prev == 10));
				check_value("out_en", 32'(out_en), 32'(prev == 11));
			end
			if (op < 64) drive_opcode(op);
		end
		report_test("reg_sweep");
	endtask

	task inversion_flags;
		next_drive_point();
		drive_opcode(0);
		next_drive_point();
		drive_opcode(53); // ISRF
		#1;
		check_value("inv", 32'(inv), 0);
		next_drive_point();
		check_value("srf", 32'(srf), 1);
		check_value("inv", 32'(inv), 1);
		drive_opcode(0);
		next_drive_point();
		check_value("inv", 32'(inv), 0);
		drive_opcode(50); // ILDI
		#1;
		check_value("inv", 32'(inv), 1);
		check_value("ldi", 32'(ldi), 1);
		next_drive_point();
		drive_opcode(9); // SRF
		#1;
		check_value("ldi", 32'(ldi), 0);
		check_value("inv", 32'(inv), 0);
		next_drive_point();
		check_value("srf", 32'(srf), 1);
		check_value("inv", 32'(inv), 0);
		report_test("inversion");
	endtask

	task io_path;
		logic [31:0] sel;
		logic [31:0] io_val;
		logic [31:0] mem_val;
		int          prev;
		int          op;
		drive_opcode(0);
		prev = 0;
		for (int n = 0; n < 24; n++) begin
			next_drive_point();
			check_value("req_in", 32'(req_in), 32'(prev == 10));
			check_value("out_en", 32'(out_en), 32'(prev == 11));
			draw_random(32, io_val);
			draw_random(32, mem_val);
			draw_random(2, sel);
			case (sel[1:0])
				2'd0: op = 10; // IN
				2'd1: op = 11; // OUT
				2'd2: op = 13;
				default: op = 0;
			endcase
			io_in = io_val;
			mem_data_in = mem_val;
			drive_opcode(op);
			#1;
			check_value("ula_data", ula_data, prev == 10 ? io_val : mem_val);
			prev = op;
		end
		report_test("io_path");
	endtask

	task address_slice;
		logic [31:0] val;
		repeat (20) begin
			next_drive_point();
			draw_random(nboper, val);
			operand = val[nboper-1:0];
			#1;
			check_value("mem_addr", 32'(mem_addr), 32'(val[7:0]));
		end
		report_test("addressing");
	endtask

	initial begin
		drive_opcode(0);
		operand = '0;
		mem_data_in = '0;
		io_in = '0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset_check();
		comb_sweep();
		reg_sweep();
		inversion_flags();
		io_path();
		address_slice();
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run still busy after %0d clock cycles", watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/stack_isa_pkg.sv
verilog/mem_stack_ctrl.sv
verilog/alu_op_decode.sv
verilog/instr_dec.sv
bench/tb_clock_gen.sv
bench/instr_dec_properties.sv
bench/instr_dec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instr_dec testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module instr_dec_tb -f sim.f -o instr_dec_sim > build.log 2>&1 \
	&& ./obj_dir/instr_dec_sim > sim.log 2>&1 \
	|| echo "*** TEST FAILED ***" >> sim.log
if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "simulation failed, see sim.log and build.log"
	exit 1
fi
echo "simulation passed"
